/* Makefile */
# Verilator build and run for the multi-source flow control testbench

VERILATOR ?= verilator
TB_TOP    ?= multi_source_flow_control_tb
RTL_TOP   ?= multi_source_flow_control
FILELIST  ?= multi_source_flow_control.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* multi_source_flow_control.f */
source/chdr_pkg.sv
source/flow_control_pkg.sv
source/fc_packet_router.sv
source/credit_gate.sv
source/packet_arbiter.sv
source/multi_source_flow_control.sv
verification/multi_source_flow_control_tb.sv

/* source/chdr_pkg.sv */
/* CHDR stream word and sequence-number types, header bit positions
   and the packed beat struct shared by every stream port */
package chdr_pkg;

   // Widths of the stream data word and of a flow-control sequence number
   localparam int CHDR_W   = 64;
   localparam int SEQNUM_W = 32;

   // One data word of a CHDR stream
   typedef logic [CHDR_W-1:0] chdr_word_t;

   // Packet sequence number, compared only as a modulo-2^32 difference
   typedef logic [SEQNUM_W-1:0] seqnum_t;

   // Header bit positions in the first word of a CHDR packet
   localparam int HDR_EXT_CONTEXT_BIT = 63; // Set for extension-context packets
   localparam int HDR_HAS_TIME_BIT    = 61; // A time word follows the header

   // The SID sits in the low 32 bits of the header
   // The destination channel is taken from its lowest bits
   localparam int HDR_SID_CHAN_LSB = 0;

   // The sequence number of a credit packet sits in the low bits of its body word
   localparam int BODY_SEQNUM_LSB = 0;

   // One stream beat as it travels between blocks
   typedef struct packed {
      chdr_word_t data; // Payload word
      logic       last; // Final beat of the packet
   } chdr_beat_t;

endpackage

/* source/credit_gate.sv */
/* Per-channel window registers, window restart, packet counter and the
   go/hold gate between one input stream and the arbiter */
module credit_gate
   import chdr_pkg::*, flow_control_pkg::*;
#(
   parameter int CHANNEL = 0
) (
   input  logic           clk,
   input  logic           window_reset,
   input  logic           clear,
   input  setting_write_t set_bus,
   input  credit_update_t credit_update,
   input  chdr_beat_t     in_beat,
   input  logic           in_tvalid,
   output logic           in_tready,
   output chdr_beat_t     gated_beat,
   output logic           gated_tvalid,
   input  logic           gated_tready,
   output logic           busy
);

   // This channel's two settings registers
   localparam set_addr_t WINDOW_ADDR = chan_set_addr(CHANNEL, SET_WINDOW_OFS);
   localparam set_addr_t ENABLE_ADDR = chan_set_addr(CHANNEL, SET_ENABLE_OFS);

   window_t window_size;    // Packets allowed beyond the last consumed one
   logic    window_enable;  // Flow control active, otherwise pass freely
   logic    enable_write;   // Enable register written, starts a restart
   logic    restarting;     // Dropping stale input after a restart
   seqnum_t last_consumed;  // Last packet the host reported as consumed
   seqnum_t packet_count;   // Packets passed since the restart
   seqnum_t go_until;       // First packet number not yet allowed
   logic    go;             // Window open for the next packet
   logic    pass;           // Gate open this cycle
   logic    credit_hit;     // Credit update for this channel
   logic    last_accepted;  // Last beat of a packet handed to the arbiter

   assign enable_write = set_bus.strobe && set_bus.addr == ENABLE_ADDR;
   assign credit_hit   = credit_update.valid && credit_update.chan == chan_idx_t'(CHANNEL);

   // Window size is a plain setting with no reset
   always_ff @(posedge clk) begin
      if (set_bus.strobe && set_bus.addr == WINDOW_ADDR) begin
         window_size <= window_t'(set_bus.data);
      end
   end

   always_ff @(posedge clk) begin
      if (window_reset || clear) begin
         window_enable <= 1'b0;
      end else if (enable_write) begin
         window_enable <= set_bus.data[0];
      end
   end

   // The restart runs until upstream has nothing left queued
   always_ff @(posedge clk) begin
      if (window_reset || clear) begin
         restarting <= 1'b0;
      end else if (enable_write) begin
         restarting <= 1'b1;
      end else if (restarting && !in_tvalid) begin
         restarting <= 1'b0; // Input ran dry, stale packets are gone
      end
   end

   assign busy = restarting;

   always_ff @(posedge clk) begin
      if (window_reset || clear || enable_write) begin
         last_consumed <= LAST_CONSUMED_INIT;
      end else if (credit_hit) begin
         last_consumed <= credit_update.seqnum; // Host returned credit
      end
   end

   assign last_accepted = gated_tvalid && gated_tready && gated_beat.last;

   // Counting on the last beat means a hold only ever falls between packets
   always_ff @(posedge clk) begin
      if (window_reset || clear || restarting) begin
         packet_count <= '0;
      end else if (last_accepted) begin
         packet_count <= packet_count + seqnum_t'(1);
      end
   end

   assign go_until = last_consumed + window_size + seqnum_t'(1);

   always_ff @(posedge clk) begin
      if (window_reset || clear || enable_write) begin
         go <= 1'b0;
      end else if (!window_enable) begin
         go <= 1'b1; // No flow control, always open
      end else if (!go) begin
         // Difference test so that a 32-bit wrap needs no extra logic
         if (in_tvalid && (go_until - packet_count) != '0) begin
            go <= 1'b1;
         end
      end else if (last_accepted) begin
         go <= 1'b0; // Recheck the window before the next packet
      end
   end

   // Disabled windows pass from the first cycle after reset
   assign pass = go || !window_enable;

   // During a restart every input beat is taken and thrown away
   assign in_tready    = restarting || (pass && gated_tready);
   assign gated_tvalid = pass && !restarting && in_tvalid;
   assign gated_beat   = in_beat; // Data flows through without delay

   // Without a restart the window closes only between packets
   assert property (@(posedge clk) disable iff (window_reset || clear)
      (gated_tvalid && gated_tready && !gated_beat.last && !enable_write) |=> pass)
      else $error("channel %0d closed its window inside a packet", CHANNEL);

endmodule

/* source/fc_packet_router.sv */
/* Credit packet parser that turns extension-context packets on the shared
   flow-control stream into sequence-number updates for one channel */
module fc_packet_router
   import chdr_pkg::*, flow_control_pkg::*;
(
   input  logic           clk,
   input  logic           window_reset,
   input  logic           clear,
   input  chdr_beat_t     fc_beat,
   input  logic           fc_tvalid,
   output logic           fc_tready,
   input  chan_mask_t     busy,
   output credit_update_t credit_update
);

   fc_state_t state;         // Position inside the current credit packet
   logic      fc_accept;     // A credit stream beat transfers this cycle
   chan_idx_t chan_q;        // Destination channel from the header SID
   logic      update_valid;  // Registered strobe towards the gates
   seqnum_t   update_seqnum; // Registered sequence number from the body word

   // Credits are held off while any window restarts, so no update races a restart
   assign fc_tready = ~|busy;
   assign fc_accept = fc_tvalid & fc_tready;

   always_ff @(posedge clk) begin
      if (window_reset || clear) begin
         state <= FC_HEAD;
      end else if (fc_accept) begin
         case (state)
            FC_HEAD: begin
               if (fc_beat.last) begin
                  state <= FC_HEAD; // Header-only packet, nothing to parse
               end else if (!fc_beat.data[HDR_EXT_CONTEXT_BIT]) begin
                  state <= FC_DUMP; // Only extension context carries credit
               end else if (fc_beat.data[HDR_HAS_TIME_BIT]) begin
                  state <= FC_TIME;
               end else begin
                  state <= FC_BODY;
               end
            end
            FC_TIME: begin
               // The time word is skipped, a packet ending here has no body
               state <= fc_beat.last ? FC_HEAD : FC_BODY;
            end
            FC_BODY: begin
               state <= fc_beat.last ? FC_HEAD : FC_DUMP; // Extra words are bad
            end
            default: begin
               if (fc_beat.last) begin
                  state <= FC_HEAD;
               end
            end
         endcase
      end
   end

   // Channel and sequence number are payload and need no reset
   always_ff @(posedge clk) begin
      if (fc_accept && state == FC_HEAD) begin
         chan_q <= fc_beat.data[HDR_SID_CHAN_LSB +: CHAN_IDX_W];
      end
      if (fc_accept && state == FC_BODY) begin
         update_seqnum <= fc_beat.data[BODY_SEQNUM_LSB +: SEQNUM_W];
      end
   end

   // The update only fires when the body word also ends the packet
   // A packet with extra body words falls into the dump state without credit
   always_ff @(posedge clk) begin
      if (window_reset || clear) begin
         update_valid <= 1'b0;
      end else begin
         update_valid <= fc_accept && state == FC_BODY && fc_beat.last;
      end
   end

   assign credit_update.valid  = update_valid;
   assign credit_update.chan   = chan_q;        // Stable until the next header
   assign credit_update.seqnum = update_seqnum;

   // One credit packet gives exactly one single-cycle update
   assert property (@(posedge clk) disable iff (window_reset || clear)
      credit_update.valid |=> !credit_update.valid)
      else $error("credit update valid on two consecutive cycles");

endmodule

/* source/flow_control_pkg.sv */
/* Channel count, settings address map, window and channel types,
   credit parser states and the credit-update struct */
package flow_control_pkg;
   import chdr_pkg::*;

   // Number of gated input streams merged onto the output
   localparam int NUM_CHANNELS = 4;
   localparam int CHAN_IDX_W   = $clog2(NUM_CHANNELS);

   typedef logic [CHAN_IDX_W-1:0]   chan_idx_t;  // Channel number
   typedef logic [NUM_CHANNELS-1:0] chan_mask_t; // One bit per channel

   typedef logic [31:0] window_t;   // Window size in packets
   typedef logic [7:0]  set_addr_t; // Settings register address
   typedef logic [31:0] set_data_t; // Settings register value

   // Settings address map
   // Each channel owns two consecutive registers starting at SET_BASE
   localparam int SET_BASE          = 0;
   localparam int SET_REGS_PER_CHAN = 2;
   localparam int SET_WINDOW_OFS    = 0; // Window size register
   localparam int SET_ENABLE_OFS    = 1; // Window enable, a write restarts the window

   // Value of the last-consumed register right after a window restart
   // With it the first packet to pass is number zero
   localparam seqnum_t LAST_CONSUMED_INIT = '1;

   // Write-only settings bus, one write per strobe
   typedef struct packed {
      logic      strobe; // Write this cycle
      set_addr_t addr;
      set_data_t data;
   } setting_write_t;

   // Sequence-number update from the credit parser to the gates
   typedef struct packed {
      logic      valid;  // High for one cycle per accepted credit packet
      chan_idx_t chan;   // Channel that the credit is for
      seqnum_t   seqnum; // Last packet consumed by the host on that channel
   } credit_update_t;

   // Credit packet parser states
   typedef enum logic [1:0] {
      FC_HEAD, // Waiting for a header
      FC_TIME, // Skipping the time word
      FC_BODY, // Next word holds the sequence number
      FC_DUMP  // Discarding the rest of a bad packet
   } fc_state_t;

   // Address of one register of a channel
   function automatic set_addr_t chan_set_addr(input int chan, input int ofs);
      return set_addr_t'(SET_BASE + SET_REGS_PER_CHAN * chan + ofs);
   endfunction

endpackage

/* source/multi_source_flow_control.sv */
/* Four-channel source flow control with the credit parser, one credit gate
   per input stream and the packet arbiter */
module multi_source_flow_control
   import chdr_pkg::*, flow_control_pkg::*;
(
   input  logic           clk,
   input  logic           window_reset,
   input  logic           clear,
   input  setting_write_t set_bus,
   input  chdr_beat_t     fc_beat,
   input  logic           fc_tvalid,
   output logic           fc_tready,
   input  chdr_beat_t     in_beat [NUM_CHANNELS],
   input  chan_mask_t     in_tvalid,
   output chan_mask_t     in_tready,
   output chdr_beat_t     out_beat,
   output logic           out_tvalid,
   input  logic           out_tready,
   output chan_idx_t      out_chan,
   output chan_mask_t     busy
);

   credit_update_t credit_update;              // Broadcast to every gate
   chdr_beat_t     gated_beat [NUM_CHANNELS];
   chan_mask_t     gated_tvalid;
   chan_mask_t     gated_tready;

   fc_packet_router u_router (
      .clk, .window_reset, .clear,
      .fc_beat, .fc_tvalid, .fc_tready,
      .busy, .credit_update
   );

   // One window per input stream, each decodes its own settings addresses
   for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_gate
      credit_gate #(.CHANNEL(c)) u_gate (
         .clk, .window_reset, .clear,
         .set_bus, .credit_update,
         .in_beat      (in_beat[c]),
         .in_tvalid    (in_tvalid[c]),
         .in_tready    (in_tready[c]),
         .gated_beat   (gated_beat[c]),
         .gated_tvalid (gated_tvalid[c]),
         .gated_tready (gated_tready[c]),
         .busy         (busy[c])
      );
   end

   packet_arbiter u_arbiter (
      .clk, .window_reset, .clear,
      .gated_beat, .gated_tvalid, .gated_tready,
      .out_beat, .out_tvalid, .out_tready, .out_chan
   );

endmodule

/* source/packet_arbiter.sv */
/* Round-robin merge of the gated channel streams onto one output,
   locked to one channel from a packet's first beat to its last */
module packet_arbiter
   import chdr_pkg::*, flow_control_pkg::*;
(
   input  logic       clk,
   input  logic       window_reset,
   input  logic       clear,
   input  chdr_beat_t gated_beat [NUM_CHANNELS],
   input  chan_mask_t gated_tvalid,
   output chan_mask_t gated_tready,
   output chdr_beat_t out_beat,
   output logic       out_tvalid,
   input  logic       out_tready,
   output chan_idx_t  out_chan
);

   chan_idx_t grant_q;  // Current channel while locked, else last granted
   logic      locked;   // A packet is open on grant_q
   chan_idx_t pick;     // Next requester after grant_q
   chan_idx_t active;   // Channel that owns the output this cycle
   logic      pkt_done; // Last beat of the packet transfers

   // Search starts just after the last granted channel
   always_comb begin
      int idx;
      pick = grant_q;
      for (int i = NUM_CHANNELS; i >= 1; i--) begin
         idx = (int'(grant_q) + i) % NUM_CHANNELS;
         if (gated_tvalid[idx]) begin
            pick = chan_idx_t'(idx); // Lowest offset wins, so loop runs backwards
         end
      end
   end

   assign active     = locked ? grant_q : pick;
   assign out_chan   = active;
   assign out_beat   = gated_beat[active];
   assign out_tvalid = gated_tvalid[active];
   assign pkt_done   = out_tvalid && out_tready && out_beat.last;

   always_comb begin
      gated_tready         = '0;
      gated_tready[active] = out_tready; // Only the owner sees ready
   end

   // Lock as soon as a beat is offered so the offer cannot be withdrawn
   always_ff @(posedge clk) begin
      if (window_reset || clear) begin
         grant_q <= chan_idx_t'(NUM_CHANNELS - 1); // Channel 0 is served first
         locked  <= 1'b0;
      end else if (out_tvalid) begin
         grant_q <= active;
         locked  <= !pkt_done;
      end
   end

   // Packets never interleave on the output
   assert property (@(posedge clk) disable iff (window_reset || clear)
      (out_tvalid && !pkt_done) |=> out_chan == $past(out_chan))
      else $error("grant moved while a packet was open");

endmodule

/* verification/multi_source_flow_control_tb.sv */
/* Table-driven testbench for the four-channel source flow control with
   stimulus queues, output scoreboard, compare tasks and a cycle timeout */
module multi_source_flow_control_tb
   import chdr_pkg::*, flow_control_pkg::*;
();

   localparam int NUM_ROWS    = 15;
   localparam int CYCLE_LIMIT = 64 * NUM_ROWS; // 64 cycles per table row

   // Row operations and credit packet kinds
   localparam int OP_BURST = 0, OP_ALL = 1, OP_WRITE = 2, OP_CREDIT = 3;
   localparam int K_GOOD = 0, K_TIME = 1, K_HDR = 2, K_NONEXT = 3, K_EXTRA = 4;

   typedef struct {
      int op;
      int chan;                 // Channel for bursts and credits
      int arg;                  // Packet count, settings address or sequence number
      int arg2;                 // Settings data or credit kind
      int exp [NUM_CHANNELS];   // Packets passed per channel since its last restart
   } row_t;

   logic           clk;
   logic           window_reset;
   logic           clear;
   setting_write_t set_bus;
   chdr_beat_t     fc_beat;
   logic           fc_tvalid;
   logic           fc_tready;
   chdr_beat_t     in_beat [NUM_CHANNELS];
   chan_mask_t     in_tvalid;
   chan_mask_t     in_tready;
   chdr_beat_t     out_beat;
   logic           out_tvalid;
   logic           out_tready;
   chan_idx_t      out_chan;
   chan_mask_t     busy;

   row_t       rows [NUM_ROWS];
   chdr_beat_t in_q  [NUM_CHANNELS][$]; // Beats still to be offered per channel
   chdr_beat_t exp_q [NUM_CHANNELS][$]; // Beats expected at the output per channel
   chdr_beat_t fc_q [$];                // Credit stream beats
   seqnum_t    pass_cnt [NUM_CHANNELS];
   int         pkt_idx [NUM_CHANNELS];
   chan_mask_t busy_seen;
   int         seed = 37034;
   int         errors = 0;
   int         checks = 0;
   int         cycles = 0;
   logic       open_pkt = 1'b0;          // Output packet in flight
   chan_idx_t  last_grant = chan_idx_t'(NUM_CHANNELS - 1);

   multi_source_flow_control uut (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic check_count(input string what, input seqnum_t got, input seqnum_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s count %0d expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_beat(input chdr_beat_t got, input chdr_beat_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: beat %h/%b expected %h/%b", $time,
                  got.data, got.last, exp.data, exp.last);
      end
   endtask

   task automatic check_chan(input string what, input chan_idx_t got, input chan_idx_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s channel %0d expected %0d", $time, what, got, exp);
      end
   endtask

   // Round-robin rule, first requester after the last granted channel
   function automatic chan_idx_t rr_next(input chan_idx_t last, input chan_mask_t req);
      int idx;
      for (int i = 1; i <= NUM_CHANNELS; i++) begin
         idx = (int'(last) + i) % NUM_CHANNELS;
         if (req[idx]) return chan_idx_t'(idx);
      end
      return last;
   endfunction

   // Cycle limit for the whole run
   always @(posedge clk) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         $display("Run stopped: cycle limit of %0d reached", CYCLE_LIMIT);
         $display("** FAIL **");
         $finish;
      end
   end

   // Scoreboard and stream drivers, all on the rising edge
   always @(posedge clk) begin
      busy_seen <= busy_seen | busy;
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         if (busy[c]) exp_q[c].delete(); // Restart throws the queued packets away
      end
      if (out_tvalid && !window_reset) begin
         if (!open_pkt) begin
            check_chan("grant", out_chan, rr_next(last_grant, uut.gated_tvalid));
         end else begin
            check_chan("locked", out_chan, last_grant); // No interleaving
         end
         last_grant = out_chan;
         open_pkt = !(out_tready && out_beat.last);
         if (out_tready) begin
            check_chan("tag", out_chan, chan_idx_t'(out_beat.data[63:56]));
            if (exp_q[out_chan].size() == 0) begin
               errors++;
               $display("Channel %0d sent a beat that was never queued", out_chan);
            end else begin
               check_beat(out_beat, exp_q[out_chan].pop_front());
            end
            if (out_beat.last) pass_cnt[out_chan]++;
         end
      end
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         if (in_tvalid[c] && in_tready[c]) void'(in_q[c].pop_front());
         in_tvalid[c] <= in_q[c].size() != 0;
         if (in_q[c].size() != 0) in_beat[c] <= in_q[c][0];
      end
      if (fc_tvalid && fc_tready) void'(fc_q.pop_front());
      fc_tvalid <= fc_q.size() != 0;
      if (fc_q.size() != 0) fc_beat <= fc_q[0];
      out_tready <= ($unsigned($random(seed)) % 8) != 0; // About one stall in eight
   end

   // Packet data is channel tag, packet index and beat index
   task automatic queue_packet(input int c);
      int         len;
      chdr_beat_t beat;
      len = 1 + $unsigned($random(seed)) % 4;
      for (int b = 0; b < len; b++) begin
         beat.data = {8'(c), 24'(pkt_idx[c]), 32'(b)};
         beat.last = (b == len - 1);
         in_q[c].push_back(beat);
         exp_q[c].push_back(beat);
      end
      pkt_idx[c]++;
   endtask

   task automatic queue_credit(input int c, input int seq, input int kind);
      chdr_word_t hdr;
      hdr = chdr_word_t'(c);
      hdr[HDR_EXT_CONTEXT_BIT] = (kind != K_NONEXT);
      hdr[HDR_HAS_TIME_BIT]    = (kind == K_TIME);
      fc_q.push_back('{data: hdr, last: kind == K_HDR});
      if (kind == K_HDR) return;
      if (kind == K_TIME) fc_q.push_back('{data: 64'h0123_4567_89ab_cdef, last: 1'b0});
      fc_q.push_back('{data: chdr_word_t'(seq), last: kind != K_EXTRA});
      if (kind == K_EXTRA) fc_q.push_back('{data: 64'h0, last: 1'b1});
   endtask

   task automatic write_setting(input int addr, input int data);
      @(posedge clk);
      set_bus <= '{strobe: 1'b1, addr: set_addr_t'(addr), data: set_data_t'(data)};
      @(posedge clk);
      set_bus.strobe <= 1'b0;
   endtask

   // Settled when the output, the credit stream and every restart are idle
   task automatic wait_quiet();
      int quiet;
      quiet = 0;
      repeat (2) @(negedge clk);
      while (quiet < 6) begin
         @(negedge clk);
         if (!out_tvalid && busy == '0 && fc_q.size() == 0 && !fc_tvalid) quiet++;
         else quiet = 0;
      end
   endtask

   initial begin
      // Channel 1 carries the windowed tests with a window of 2
      rows[0]  = '{OP_BURST,  0, 3, 0,        '{3, 0, 0, 0}};
      rows[1]  = '{OP_ALL,    0, 2, 0,        '{5, 2, 2, 2}};
      rows[2]  = '{OP_WRITE,  0, 2, 2,        '{5, 2, 2, 2}};
      rows[3]  = '{OP_WRITE,  0, 3, 1,        '{5, 0, 2, 2}};
      rows[4]  = '{OP_BURST,  1, 4, 0,        '{5, 2, 2, 2}};
      rows[5]  = '{OP_CREDIT, 1, 0, K_GOOD,   '{5, 3, 2, 2}};
      rows[6]  = '{OP_CREDIT, 1, 9, K_HDR,    '{5, 3, 2, 2}};
      rows[7]  = '{OP_CREDIT, 1, 5, K_NONEXT, '{5, 3, 2, 2}};
      rows[8]  = '{OP_CREDIT, 1, 5, K_EXTRA,  '{5, 3, 2, 2}};
      rows[9]  = '{OP_CREDIT, 1, 1, K_TIME,   '{5, 4, 2, 2}};
      rows[10] = '{OP_BURST,  1, 3, 0,        '{5, 4, 2, 2}};
      rows[11] = '{OP_WRITE,  0, 3, 1,        '{5, 0, 2, 2}};
      rows[12] = '{OP_BURST,  1, 3, 0,        '{5, 2, 2, 2}};
      rows[13] = '{OP_WRITE,  0, 3, 0,        '{5, 0, 2, 2}};
      rows[14] = '{OP_ALL,    0, 3, 0,        '{8, 3, 5, 5}};

      window_reset = 1'b1;
      clear        = 1'b0;
      set_bus      = '0;
      fc_beat      = '0;
      fc_tvalid    = 1'b0;
      in_tvalid    = '0;
      out_tready   = 1'b0;
      busy_seen    = '0;
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         in_beat[c]  = '0;
         pass_cnt[c] = '0;
         pkt_idx[c]  = 0;
      end
      repeat (3) @(posedge clk);
      window_reset <= 1'b0;

      for (int r = 0; r < NUM_ROWS; r++) begin
         @(negedge clk);
         case (rows[r].op)
            OP_BURST: for (int p = 0; p < rows[r].arg; p++) queue_packet(rows[r].chan);
            OP_ALL: begin
               for (int p = 0; p < rows[r].arg; p++) begin
                  for (int c = 0; c < NUM_CHANNELS; c++) queue_packet(c);
               end
            end
            OP_CREDIT: queue_credit(rows[r].chan, rows[r].arg, rows[r].arg2);
            default: begin
               if (rows[r].arg % 2 == 1) begin
                  pass_cnt[rows[r].arg / 2] = '0; // Enable write starts the count again
                  busy_seen = '0;
               end
               write_setting(rows[r].arg, rows[r].arg2);
            end
         endcase
         wait_quiet();
         if (rows[r].op == OP_WRITE && rows[r].arg % 2 == 1 && !busy_seen[rows[r].arg / 2]) begin
            errors++;
            $display("Channel %0d never raised busy after its enable write", rows[r].arg / 2);
         end
         // A held channel must stop between packets, never inside one
         if (open_pkt) begin
            errors++;
            $display("Row %0d left a packet open on channel %0d", r, last_grant);
         end
         for (int c = 0; c < NUM_CHANNELS; c++) begin
            check_count($sformatf("row %0d chan %0d", r, c), pass_cnt[c],
                        seqnum_t'(rows[r].exp[c]));
         end
         $display("Row %0d done, %0d errors so far", r, errors);
      end

      $display("%0d rows, %0d checks, %0d errors", NUM_ROWS, checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule
